// ==== common/l15_adapter_pkg.sv ====
// Adapter widths, request/return/size encodings, byte swap and store replicate functions
package l15_adapter_pkg;

    localparam int unsigned PA_W       = 40;
    localparam int unsigned L15_DATA_W = 64;
    localparam int unsigned MEM_DATA_W = 256;  // Four L1.5 return dwords
    localparam int unsigned MEM_BE_W   = 8;
    localparam int unsigned LINE_OFF_W = 4;

    typedef enum logic [1:0] {
        REQ_IMISS = 2'd0,
        REQ_LOAD  = 2'd1,
        REQ_STORE = 2'd2
    } req_kind_e;

    typedef enum logic [4:0] {
        L15_LOAD_RQ  = 5'b00000,
        L15_STORE_RQ = 5'b00001,
        L15_IMISS_RQ = 5'b10000
    } l15_rqtype_e;

    typedef enum logic [3:0] {
        L15_LOAD_RET  = 4'b0000,
        L15_IFILL_RET = 4'b0001,
        L15_EVICT_REQ = 4'b0011,
        L15_ST_ACK    = 4'b0100,
        L15_ERR_RET   = 4'b1100
    } l15_rtrntype_e;

    typedef enum logic [2:0] {
        SIZE_1B   = 3'd0,
        SIZE_2B   = 3'd1,
        SIZE_4B   = 3'd2,
        SIZE_8B   = 3'd3,
        SIZE_LINE = 3'd7
    } l15_size_e;

    // Reverse byte order of one dword
    function automatic logic [L15_DATA_W-1:0] swap_dword(input logic [L15_DATA_W-1:0] data);
        logic [L15_DATA_W-1:0] res;
        for (int i = 0; i < 8; i++) begin
            res[i*8 +: 8] = data[(7-i)*8 +: 8];
        end
        return res;
    endfunction

    // Copy a narrow store value from its lane into every lane of the dword
    function automatic logic [L15_DATA_W-1:0] replicate_dword(input logic [L15_DATA_W-1:0] data,
                                                              input logic [2:0] offset,
                                                              input logic [1:0] size);
        logic [5:0]            base;
        logic [L15_DATA_W-1:0] res;
        base = {offset, 3'b000};
        case (size)
            2'd0:    res = {8{data[base +: 8]}};
            2'd1:    res = {4{data[base +: 16]}};
            2'd2:    res = {2{data[base +: 32]}};
            default: res = data;  // Full dword already
        endcase
        return res;
    endfunction

endpackage

// ==== request/l15_store_align.sv ====
// Store size code, byte offset and aligned address derived from byte enables
`timescale 1ns/1ps

module l15_store_align import l15_adapter_pkg::*; (
    input  logic [MEM_BE_W-1:0] be_i,
    input  logic [PA_W-1:0]     addr_i,
    output l15_size_e           size_o,
    output logic [2:0]          offset_o,
    output logic [PA_W-1:0]     addr_o
);

    logic [3:0] be_cnt;
    logic [2:0] low_lane;

    assign be_cnt = 4'($countones(be_i));

    // Lowest enabled byte lane
    always_comb begin
        low_lane = '0;
        for (int i = MEM_BE_W - 1; i >= 0; i--) begin
            if (be_i[i]) begin
                low_lane = 3'(i);
            end
        end
    end

    always_comb begin
        size_o   = SIZE_LINE;
        offset_o = '0;
        addr_o   = addr_i;
        case (be_cnt)
            4'd1, 4'd2, 4'd4: begin
                size_o   = (be_cnt == 4'd1) ? SIZE_1B :
                           (be_cnt == 4'd2) ? SIZE_2B : SIZE_4B;
                offset_o = low_lane;
                addr_o   = {addr_i[PA_W-1:3], low_lane};  // Offset replaces low bits
            end
            4'd8:    size_o = SIZE_8B;  // Whole dword, address kept
            default: size_o = SIZE_LINE;
        endcase
    end

    // Enables of a store cover a power-of-two number of bytes
    always_comb begin
        if (!$isunknown(be_i) && be_i != '0) begin
            assert (be_cnt == 4'd1 || be_cnt == 4'd2 || be_cnt == 4'd4 || be_cnt == 4'd8)
                else $error("store byte enables %b are not 1, 2, 4 or 8 bytes", be_i);
        end
    end

endmodule

// ==== request/l15_req_encode.sv ====
// L1.5 request type, nc flag, size code, address and data built from a cache request
`timescale 1ns/1ps

module l15_req_encode import l15_adapter_pkg::*; #(
    parameter bit SWAP_ENDIAN = 1'b1
) (
    input  req_kind_e             req_kind_i,
    input  logic [PA_W-1:0]       req_addr_i,
    input  l15_size_e             req_size_i,
    input  logic                  req_cacheable_i,
    input  logic [MEM_BE_W-1:0]   req_be_i,
    input  logic [L15_DATA_W-1:0] req_wdata_i,
    output l15_rqtype_e           l15_rqtype_o,
    output logic                  l15_nc_o,
    output l15_size_e             l15_size_o,
    output logic [PA_W-1:0]       l15_address_o,
    output logic [L15_DATA_W-1:0] l15_data_o
);

    l15_size_e             st_size;
    logic [2:0]            st_offset;
    logic [PA_W-1:0]       st_addr;
    logic [L15_DATA_W-1:0] st_data;
    logic                  is_store;

    l15_store_align i_store_align (
        .be_i     (req_be_i),
        .addr_i   (req_addr_i),
        .size_o   (st_size),
        .offset_o (st_offset),
        .addr_o   (st_addr)
    );

    assign is_store = (req_kind_i == REQ_STORE);
    assign l15_nc_o = ~req_cacheable_i;

    always_comb begin
        case (req_kind_i)
            REQ_IMISS: l15_rqtype_o = L15_IMISS_RQ;
            REQ_STORE: l15_rqtype_o = L15_STORE_RQ;
            default:   l15_rqtype_o = L15_LOAD_RQ;
        endcase
    end

    always_comb begin
        if (req_kind_i == REQ_IMISS) begin
            // Full line when cacheable, single word otherwise
            l15_size_o = req_cacheable_i ? SIZE_LINE : SIZE_4B;
        end else if (is_store) begin
            l15_size_o = st_size;
        end else if (req_size_i == 3'd4) begin  // 16-byte load
            l15_size_o = SIZE_LINE;
        end else begin
            l15_size_o = req_size_i;
        end
    end

    assign l15_address_o = is_store ? st_addr : req_addr_i;

    // Narrow stores go out replicated over the dword
    assign st_data = is_store ? replicate_dword(req_wdata_i, st_offset, st_size[1:0])
                              : req_wdata_i;

    assign l15_data_o = SWAP_ENDIAN ? swap_dword(st_data) : st_data;

endmodule

// ==== source/l15_thread_table.sv ====
// Two-entry L1.5 thread ID FSM with stored transaction and port IDs
`timescale 1ns/1ps

module l15_thread_table #(
    parameter int unsigned ID_W  = 4,
    parameter int unsigned PID_W = 2
) (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             req_fire_i,
    input  logic [ID_W-1:0]  req_id_i,
    input  logic [PID_W-1:0] req_pid_i,
    input  logic             resp_fire_i,
    input  logic             rtrn_thread_i,
    output logic             thread_free_o,
    output logic             req_thread_o,
    output logic [ID_W-1:0]  resp_id_o,
    output logic [PID_W-1:0] resp_pid_o
);

    typedef enum logic [1:0] {
        FREE_T0_T1,
        FREE_T0,       // Only thread 0 free
        FREE_T1,       // Only thread 1 free
        LOCKED_T0_T1
    } th_state_e;

    th_state_e        state_q, state_d;
    logic [1:0]       busy, busy_d;
    logic [ID_W-1:0]  tid_q [2];
    logic [PID_W-1:0] pid_q [2];

    // Per-thread busy view of the state
    always_comb begin
        case (state_q)
            FREE_T0_T1: busy = 2'b00;
            FREE_T0:    busy = 2'b10;
            FREE_T1:    busy = 2'b01;
            default:    busy = 2'b11;
        endcase
    end

    assign thread_free_o = (state_q != LOCKED_T0_T1);
    assign req_thread_o  = (state_q == FREE_T1);  // Thread 0 preferred

    always_comb begin
        busy_d = busy;
        if (resp_fire_i) begin
            busy_d[rtrn_thread_i] = 1'b0;
        end
        if (req_fire_i) begin
            busy_d[req_thread_o] = 1'b1;
        end
        case (busy_d)
            2'b00:   state_d = FREE_T0_T1;
            2'b10:   state_d = FREE_T0;
            2'b01:   state_d = FREE_T1;
            default: state_d = LOCKED_T0_T1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= FREE_T0_T1;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire_i) begin
            tid_q[req_thread_o] <= req_id_i;
            pid_q[req_thread_o] <= req_pid_i;
        end
    end

    assign resp_id_o  = tid_q[rtrn_thread_i];
    assign resp_pid_o = pid_q[rtrn_thread_i];

    // Returns only come back on threads holding a request
    a_resp_on_busy_thread: assert property (
        @(posedge clk_i) disable iff (!rst_ni) resp_fire_i |-> busy[rtrn_thread_i]
    ) else $error("response on free thread %0d", rtrn_thread_i);

endmodule

// ==== source/l15_resp_decode.sv ====
// L1.5 return classification, acknowledge, response data and flags, invalidation address
`timescale 1ns/1ps

module l15_resp_decode import l15_adapter_pkg::*; #(
    parameter bit SWAP_ENDIAN = 1'b1
) (
    input  logic                  rtrn_val_i,
    input  l15_rtrntype_e         rtrn_type_i,
    input  logic                  rtrn_dinval_i,
    input  logic [MEM_DATA_W-1:0] rtrn_data_i,
    input  logic [PA_W-1:0]       rtrn_addr_i,
    input  logic                  resp_ready_i,
    input  logic                  inval_space_i,
    output logic                  resp_valid_o,
    output logic                  resp_error_o,
    output logic [MEM_DATA_W-1:0] resp_data_o,
    output logic                  l15_req_ack_o,
    output logic                  inval_push_o,
    output logic [PA_W-1:0]       inval_addr_o
);

    logic is_inval;

    assign is_inval = (rtrn_type_i == L15_EVICT_REQ) && rtrn_dinval_i;

    // Invalidations wait for FIFO space, everything else for the cache
    assign l15_req_ack_o = is_inval ? (rtrn_val_i & inval_space_i)
                                    : (rtrn_val_i & resp_ready_i);
    assign resp_valid_o  = rtrn_val_i & ~is_inval;
    assign inval_push_o  = rtrn_val_i & is_inval & inval_space_i;
    assign resp_error_o  = (rtrn_type_i == L15_ERR_RET);

    assign inval_addr_o = {rtrn_addr_i[PA_W-1:LINE_OFF_W], {LINE_OFF_W{1'b0}}};

    for (genvar g = 0; g < MEM_DATA_W / L15_DATA_W; g++) begin : g_dword
        if (SWAP_ENDIAN) begin : g_swap
            assign resp_data_o[g*L15_DATA_W +: L15_DATA_W] =
                swap_dword(rtrn_data_i[g*L15_DATA_W +: L15_DATA_W]);
        end else begin : g_keep
            assign resp_data_o[g*L15_DATA_W +: L15_DATA_W] =
                rtrn_data_i[g*L15_DATA_W +: L15_DATA_W];
        end
    end

endmodule

// ==== source/l15_inval_fifo.sv ====
// Register FIFO of pending data-cache invalidation line addresses
`timescale 1ns/1ps

module l15_inval_fifo import l15_adapter_pkg::*; #(
    parameter int unsigned INVAL_DEPTH = 2
) (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            push_i,
    input  logic [PA_W-1:0] addr_i,
    input  logic            pop_ready_i,
    output logic            space_o,
    output logic            valid_o,
    output logic [PA_W-1:0] addr_o
);

    localparam int unsigned PTR_W = (INVAL_DEPTH > 1) ? $clog2(INVAL_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(INVAL_DEPTH + 1);

    logic [PA_W-1:0]  mem_q [INVAL_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;

    assign space_o = (count_q != CNT_W'(INVAL_DEPTH));
    assign valid_o = (count_q != '0);
    assign addr_o  = mem_q[rd_ptr_q];
    assign pop     = valid_o & pop_ready_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(INVAL_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(INVAL_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= addr_i;
        end
    end

    a_no_push_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni) push_i |-> space_o
    ) else $error("invalidation pushed into full FIFO");

endmodule

// ==== source/hpdc_l15_adapter.sv ====
// Cache to L1.5 adapter top with request, thread table, response and invalidation blocks
`timescale 1ns/1ps

module hpdc_l15_adapter import l15_adapter_pkg::*; #(
    parameter int unsigned ID_W        = 4,
    parameter int unsigned PID_W       = 2,
    parameter bit          SWAP_ENDIAN = 1'b1,
    parameter int unsigned INVAL_DEPTH = 2
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  req_valid_i,
    input  req_kind_e             req_kind_i,
    input  logic [PA_W-1:0]       req_addr_i,
    input  l15_size_e             req_size_i,
    input  logic                  req_cacheable_i,
    input  logic [MEM_BE_W-1:0]   req_be_i,
    input  logic [L15_DATA_W-1:0] req_wdata_i,
    input  logic [ID_W-1:0]       req_id_i,
    input  logic [PID_W-1:0]      req_pid_i,
    output logic                  req_ready_o,
    input  logic                  resp_ready_i,
    output logic                  resp_valid_o,
    output logic [ID_W-1:0]       resp_id_o,
    output logic [PID_W-1:0]      resp_pid_o,
    output logic                  resp_error_o,
    output logic [MEM_DATA_W-1:0] resp_data_o,
    input  logic                  hpdc_inval_ready_i,
    output logic                  hpdc_inval_valid_o,
    output logic [PA_W-1:0]       hpdc_inval_addr_o,
    input  logic                  l15_ack_i,
    output logic                  l15_val_o,
    output l15_rqtype_e           l15_rqtype_o,
    output logic                  l15_nc_o,
    output l15_size_e             l15_size_o,
    output logic                  l15_threadid_o,
    output logic [PA_W-1:0]       l15_address_o,
    output logic [L15_DATA_W-1:0] l15_data_o,
    input  logic                  l15_rtrn_val_i,
    input  l15_rtrntype_e         l15_rtrn_type_i,
    input  logic                  l15_rtrn_threadid_i,
    input  logic                  l15_rtrn_dinval_i,
    input  logic [MEM_DATA_W-1:0] l15_rtrn_data_i,
    input  logic [PA_W-1:0]       l15_rtrn_addr_i,
    output logic                  l15_req_ack_o
);

    logic            thread_free;
    logic            req_fire, resp_fire;
    logic            inval_push, inval_space;
    logic [PA_W-1:0] inval_addr;

    assign req_ready_o = l15_ack_i & thread_free;
    assign l15_val_o   = req_valid_i & thread_free;
    assign req_fire    = req_valid_i & l15_ack_i & thread_free;
    assign resp_fire   = resp_valid_o & resp_ready_i;  // Invalidations never free a thread

    l15_req_encode #(.SWAP_ENDIAN(SWAP_ENDIAN)) i_req_encode (
        .req_kind_i      (req_kind_i),
        .req_addr_i      (req_addr_i),
        .req_size_i      (req_size_i),
        .req_cacheable_i (req_cacheable_i),
        .req_be_i        (req_be_i),
        .req_wdata_i     (req_wdata_i),
        .l15_rqtype_o    (l15_rqtype_o),
        .l15_nc_o        (l15_nc_o),
        .l15_size_o      (l15_size_o),
        .l15_address_o   (l15_address_o),
        .l15_data_o      (l15_data_o)
    );

    l15_thread_table #(.ID_W(ID_W), .PID_W(PID_W)) i_thread_table (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .req_fire_i    (req_fire),
        .req_id_i      (req_id_i),
        .req_pid_i     (req_pid_i),
        .resp_fire_i   (resp_fire),
        .rtrn_thread_i (l15_rtrn_threadid_i),
        .thread_free_o (thread_free),
        .req_thread_o  (l15_threadid_o),
        .resp_id_o     (resp_id_o),
        .resp_pid_o    (resp_pid_o)
    );

    l15_resp_decode #(.SWAP_ENDIAN(SWAP_ENDIAN)) i_resp_decode (
        .rtrn_val_i    (l15_rtrn_val_i),
        .rtrn_type_i   (l15_rtrn_type_i),
        .rtrn_dinval_i (l15_rtrn_dinval_i),
        .rtrn_data_i   (l15_rtrn_data_i),
        .rtrn_addr_i   (l15_rtrn_addr_i),
        .resp_ready_i  (resp_ready_i),
        .inval_space_i (inval_space),
        .resp_valid_o  (resp_valid_o),
        .resp_error_o  (resp_error_o),
        .resp_data_o   (resp_data_o),
        .l15_req_ack_o (l15_req_ack_o),
        .inval_push_o  (inval_push),
        .inval_addr_o  (inval_addr)
    );

    l15_inval_fifo #(.INVAL_DEPTH(INVAL_DEPTH)) i_inval_fifo (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .push_i      (inval_push),
        .addr_i      (inval_addr),
        .pop_ready_i (hpdc_inval_ready_i),
        .space_o     (inval_space),
        .valid_o     (hpdc_inval_valid_o),
        .addr_o      (hpdc_inval_addr_o)
    );

endmodule

// ==== test/tb_hpdc_l15_adapter.sv ====
// Testbench for the cache to L1.5 adapter with reference models, stimulus and compare tasks
`timescale 1ns/1ps

module tb_hpdc_l15_adapter import l15_adapter_pkg::*; ();

    localparam int unsigned ID_W           = 4;
    localparam int unsigned PID_W          = 2;
    localparam bit          SWAP_ENDIAN    = 1'b1;
    localparam int unsigned INVAL_DEPTH    = 2;
    localparam int unsigned N_RAND         = 200;   // Random requests per kind
    localparam int unsigned TIMEOUT_CYCLES = 2000;  // About four times the run length
    localparam logic [31:0] SEED           = 32'hf11ed4b4;

    logic                  clk_i, rst_ni;
    logic                  req_valid_i, req_cacheable_i, req_ready_o;
    req_kind_e             req_kind_i;
    logic [PA_W-1:0]       req_addr_i;
    l15_size_e             req_size_i;
    logic [MEM_BE_W-1:0]   req_be_i;
    logic [L15_DATA_W-1:0] req_wdata_i;
    logic [ID_W-1:0]       req_id_i, resp_id_o;
    logic [PID_W-1:0]      req_pid_i, resp_pid_o;
    logic                  resp_ready_i, resp_valid_o, resp_error_o;
    logic [MEM_DATA_W-1:0] resp_data_o, l15_rtrn_data_i;
    logic                  hpdc_inval_ready_i, hpdc_inval_valid_o;
    logic [PA_W-1:0]       hpdc_inval_addr_o, l15_address_o, l15_rtrn_addr_i;
    logic                  l15_ack_i, l15_val_o, l15_nc_o, l15_threadid_o;
    l15_rqtype_e           l15_rqtype_o;
    l15_size_e             l15_size_o;
    logic [L15_DATA_W-1:0] l15_data_o;
    logic                  l15_rtrn_val_i, l15_rtrn_threadid_i, l15_rtrn_dinval_i;
    l15_rtrntype_e         l15_rtrn_type_i;
    logic                  l15_req_ack_o;

    // Model of the two threads and the pending invalidations
    logic             busy_m [2];
    logic [ID_W-1:0]  id_m   [2];
    logic [PID_W-1:0] pid_m  [2];
    logic [PA_W-1:0]  inval_q[$];
    int               cycle_cnt = 0;

    hpdc_l15_adapter #(
        .ID_W        (ID_W),
        .PID_W       (PID_W),
        .SWAP_ENDIAN (SWAP_ENDIAN),
        .INVAL_DEPTH (INVAL_DEPTH)
    ) i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, a handshake never completed", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    function automatic logic [L15_DATA_W-1:0] byte_reverse(input logic [L15_DATA_W-1:0] d);
        logic [L15_DATA_W-1:0] r;
        r = {<<8{d}};
        return SWAP_ENDIAN ? r : d;
    endfunction

    function automatic int be_bytes(input logic [MEM_BE_W-1:0] be);
        int n;
        n = 0;
        for (int i = 0; i < MEM_BE_W; i++) begin
            if (be[i]) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int be_lane(input logic [MEM_BE_W-1:0] be);
        int lane;
        lane = 0;
        for (int i = MEM_BE_W - 1; i >= 0; i--) begin
            if (be[i]) begin
                lane = i;
            end
        end
        return lane;
    endfunction

    function automatic l15_rqtype_e rqtype_model(input req_kind_e kind);
        case (kind)
            REQ_IMISS: return L15_IMISS_RQ;
            REQ_STORE: return L15_STORE_RQ;
            default:   return L15_LOAD_RQ;
        endcase
    endfunction

    function automatic l15_size_e size_model(input req_kind_e kind, input logic cacheable,
                                             input l15_size_e size, input logic [7:0] be);
        int n;
        n = be_bytes(be);
        case (kind)
            REQ_IMISS: return cacheable ? SIZE_LINE : SIZE_4B;
            REQ_STORE: return (n == 1) ? SIZE_1B : (n == 2) ? SIZE_2B :
                              (n == 4) ? SIZE_4B : (n == 8) ? SIZE_8B : SIZE_LINE;
            default:   return (size == 3'd4) ? SIZE_LINE : size;  // 16 bytes is a line
        endcase
    endfunction

    function automatic logic [PA_W-1:0] addr_model(input req_kind_e kind,
                                                   input logic [PA_W-1:0] addr,
                                                   input logic [MEM_BE_W-1:0] be);
        if (kind == REQ_STORE && be_bytes(be) != 8) begin
            return {addr[PA_W-1:3], 3'(be_lane(be))};
        end
        return addr;
    endfunction

    // Lane i of a store carries byte (i mod n) of the enabled group
    function automatic logic [L15_DATA_W-1:0] wdata_model(input req_kind_e kind,
                                                          input logic [L15_DATA_W-1:0] wdata,
                                                          input logic [MEM_BE_W-1:0] be);
        logic [L15_DATA_W-1:0] r;
        int                    n, lane;
        n    = be_bytes(be);
        lane = be_lane(be);
        r    = wdata;
        if (kind == REQ_STORE) begin
            for (int i = 0; i < 8; i++) begin
                r[8*i +: 8] = wdata[8*(lane + i % n) +: 8];
            end
        end
        return byte_reverse(r);
    endfunction

    function automatic logic [MEM_DATA_W-1:0] rdata_model(input logic [MEM_DATA_W-1:0] d);
        logic [MEM_DATA_W-1:0] r;
        for (int w = 0; w < MEM_DATA_W / L15_DATA_W; w++) begin
            r[w*L15_DATA_W +: L15_DATA_W] = byte_reverse(d[w*L15_DATA_W +: L15_DATA_W]);
        end
        return r;
    endfunction

    function automatic logic [PA_W-1:0] line_model(input logic [PA_W-1:0] addr);
        logic [PA_W-1:0] a;
        a = addr;
        a[LINE_OFF_W-1:0] = '0;
        return a;
    endfunction

    function automatic l15_rtrntype_e random_rtype();
        case ($urandom % 5)
            0:       return L15_LOAD_RET;
            1:       return L15_ST_ACK;
            2:       return L15_IFILL_RET;
            3:       return L15_ERR_RET;
            default: return L15_EVICT_REQ;  // Sent without dinval, so a plain response
        endcase
    endfunction

    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic flag_check(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic size_check(input string name, input l15_size_e exp, input l15_size_e act);
        if (act !== exp) begin
            $display("MISMATCH %s size: expected %s, actual %s", name, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic rqtype_check(input string name, input l15_rqtype_e exp,
                                input l15_rqtype_e act);
        if (act !== exp) begin
            $display("MISMATCH %s rqtype: expected %s, actual %s", name, exp.name(), act.name());
            abort_run();
        end
    endtask

    task automatic addr_check(input string name, input logic [PA_W-1:0] exp,
                              input logic [PA_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s address: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic data_check(input string name, input logic [MEM_DATA_W-1:0] exp,
                              input logic [MEM_DATA_W-1:0] act);
        if (act !== exp) begin
            $display("MISMATCH %s data: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic id_check(input string name, input logic [ID_W-1:0] exp_id,
                            input logic [PID_W-1:0] exp_pid, input logic [ID_W-1:0] act_id,
                            input logic [PID_W-1:0] act_pid);
        if (act_id !== exp_id || act_pid !== exp_pid) begin
            $display("MISMATCH %s ids: expected %h/%h, actual %h/%h",
                     name, exp_id, exp_pid, act_id, act_pid);
            abort_run();
        end
    endtask

    // All L1.5 request fields against the reference functions
    task automatic request_compare(input string name);
        flag_check({name, " l15_val"}, 1'b1, l15_val_o);
        rqtype_check(name, rqtype_model(req_kind_i), l15_rqtype_o);
        flag_check({name, " nc"}, ~req_cacheable_i, l15_nc_o);
        size_check(name, size_model(req_kind_i, req_cacheable_i, req_size_i, req_be_i),
                   l15_size_o);
        addr_check(name, addr_model(req_kind_i, req_addr_i, req_be_i), l15_address_o);
        data_check(name, MEM_DATA_W'(wdata_model(req_kind_i, req_wdata_i, req_be_i)),
                   MEM_DATA_W'(l15_data_o));
    endtask

    task automatic send_request(input logic [ID_W-1:0] id, input logic [PID_W-1:0] pid);
        logic exp_thread;
        exp_thread = busy_m[0] ? 1'b1 : 1'b0;  // Thread 0 first
        @(negedge clk_i);
        req_valid_i = 1'b1;
        req_kind_i  = REQ_LOAD;
        req_be_i    = '0;
        req_id_i    = id;
        req_pid_i   = pid;
        l15_ack_i   = 1'b1;
        #2;
        while (!req_ready_o) begin
            @(negedge clk_i);
            #2;
        end
        flag_check("request l15_val", 1'b1, l15_val_o);
        flag_check("request thread", exp_thread, l15_threadid_o);
        @(posedge clk_i);
        busy_m[exp_thread] = 1'b1;
        id_m[exp_thread]   = id;
        pid_m[exp_thread]  = pid;
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic send_return(input logic thread, input l15_rtrntype_e rtype,
                               input logic dinval);
        logic [MEM_DATA_W-1:0] data;
        logic [PA_W-1:0]       addr;
        logic                  inval;
        for (int i = 0; i < MEM_DATA_W / 32; i++) begin
            data[32*i +: 32] = $urandom;
        end
        addr  = PA_W'({$urandom, $urandom});
        inval = (rtype == L15_EVICT_REQ) && dinval;
        @(negedge clk_i);
        l15_rtrn_val_i      = 1'b1;
        l15_rtrn_type_i     = rtype;
        l15_rtrn_threadid_i = thread;
        l15_rtrn_dinval_i   = dinval;
        l15_rtrn_data_i     = data;
        l15_rtrn_addr_i     = addr;
        #2;
        while (!l15_req_ack_o) begin
            @(negedge clk_i);
            #2;
        end
        flag_check("return resp_valid", ~inval, resp_valid_o);
        if (inval) begin
            inval_q.push_back(line_model(addr));
        end else begin
            flag_check("return error", rtype == L15_ERR_RET, resp_error_o);
            data_check("return", rdata_model(data), resp_data_o);
            id_check("return", id_m[thread], pid_m[thread], resp_id_o, resp_pid_o);
        end
        @(posedge clk_i);
        if (!inval) begin
            busy_m[thread] = 1'b0;
        end
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b0;
    endtask

    task automatic drain_inval();
        logic [PA_W-1:0] exp;
        exp = inval_q.pop_front();
        @(negedge clk_i);
        hpdc_inval_ready_i = 1'b1;
        #2;
        flag_check("inval valid", 1'b1, hpdc_inval_valid_o);
        addr_check("inval", exp, hpdc_inval_addr_o);
        @(posedge clk_i);
        @(negedge clk_i);
        hpdc_inval_ready_i = 1'b0;
    endtask

    initial begin
        logic [MEM_BE_W-1:0] be;
        int                  n;
        logic                first;
        void'($urandom(SEED));
        rst_ni              = 1'b0;
        req_valid_i         = 1'b0;
        req_kind_i          = REQ_LOAD;
        req_addr_i          = '0;
        req_size_i          = SIZE_8B;
        req_cacheable_i     = 1'b0;
        req_be_i            = '0;
        req_wdata_i         = '0;
        req_id_i            = '0;
        req_pid_i           = '0;
        resp_ready_i        = 1'b1;
        hpdc_inval_ready_i  = 1'b0;
        l15_ack_i           = 1'b0;
        l15_rtrn_val_i      = 1'b0;
        l15_rtrn_type_i     = L15_LOAD_RET;
        l15_rtrn_threadid_i = 1'b0;
        l15_rtrn_dinval_i   = 1'b0;
        l15_rtrn_data_i     = '0;
        l15_rtrn_addr_i     = '0;
        busy_m              = '{1'b0, 1'b0};
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        #2;
        flag_check("reset inval valid", 1'b0, hpdc_inval_valid_o);
        flag_check("reset l15_val", 1'b0, l15_val_o);
        flag_check("reset resp_valid", 1'b0, resp_valid_o);
        flag_check("reset ready without ack", 1'b0, req_ready_o);
        @(negedge clk_i);
        l15_ack_i = 1'b1;
        #2;
        flag_check("reset ready with ack", 1'b1, req_ready_o);

        // Ack held low so field checks never take a thread
        for (int k = 0; k < N_RAND; k++) begin
            @(negedge clk_i);
            l15_ack_i       = 1'b0;
            req_valid_i     = 1'b1;
            req_kind_i      = ($urandom % 2 == 0) ? REQ_LOAD : REQ_IMISS;
            req_addr_i      = PA_W'({$urandom, $urandom});
            req_size_i      = l15_size_e'(3'($urandom % 5));
            req_cacheable_i = 1'($urandom % 2);
            req_be_i        = '0;
            req_wdata_i     = {$urandom, $urandom};
            #2;
            request_compare("load");
        end
        for (int k = 0; k < N_RAND; k++) begin
            n  = 1 << ($urandom % 4);
            be = 8'((1 << n) - 1);
            be = be << (n * int'($urandom % (8 / n)));  // Naturally aligned group
            @(negedge clk_i);
            req_kind_i      = REQ_STORE;
            req_addr_i      = PA_W'({$urandom, $urandom});
            req_cacheable_i = 1'($urandom % 2);
            req_be_i        = be;
            req_wdata_i     = {$urandom, $urandom};
            #2;
            request_compare("store");
        end

        send_request(ID_W'($urandom), PID_W'($urandom));
        send_request(ID_W'($urandom), PID_W'($urandom));
        @(negedge clk_i);
        req_valid_i         = 1'b1;
        l15_ack_i           = 1'b1;
        resp_ready_i        = 1'b0;
        l15_rtrn_val_i      = 1'b1;
        l15_rtrn_type_i     = L15_LOAD_RET;
        l15_rtrn_dinval_i   = 1'b0;
        l15_rtrn_threadid_i = 1'b1;
        repeat (2) begin  // Across a clock edge, threads must stay taken
            #2;
            flag_check("busy req_ready", 1'b0, req_ready_o);
            flag_check("busy l15_val", 1'b0, l15_val_o);
            flag_check("held return ack", 1'b0, l15_req_ack_o);
            flag_check("held return valid", 1'b1, resp_valid_o);
            id_check("held return", id_m[1], pid_m[1], resp_id_o, resp_pid_o);
            @(negedge clk_i);
        end
        req_valid_i    = 1'b0;
        l15_rtrn_val_i = 1'b0;
        resp_ready_i   = 1'b1;

        // Returns in random order, then refill both threads
        for (int k = 0; k < 8; k++) begin
            first = 1'($urandom % 2);
            send_return(first, random_rtype(), 1'b0);
            send_return(~first, random_rtype(), 1'b0);
            send_request(ID_W'($urandom), PID_W'($urandom));
            send_request(ID_W'($urandom), PID_W'($urandom));
        end
        send_return(1'b1, L15_ST_ACK, 1'b0);
        send_return(1'b0, L15_ERR_RET, 1'b0);

        for (int k = 0; k < INVAL_DEPTH; k++) begin
            send_return(1'($urandom % 2), L15_EVICT_REQ, 1'b1);
        end
        @(negedge clk_i);
        l15_rtrn_val_i    = 1'b1;
        l15_rtrn_type_i   = L15_EVICT_REQ;
        l15_rtrn_dinval_i = 1'b1;
        #2;
        flag_check("full inval ack", 1'b0, l15_req_ack_o);
        flag_check("inval resp_valid", 1'b0, resp_valid_o);
        @(negedge clk_i);
        l15_rtrn_val_i = 1'b0;
        repeat (INVAL_DEPTH) drain_inval();
        #2;
        flag_check("drained inval valid", 1'b0, hpdc_inval_valid_o);
        send_return(1'b0, L15_EVICT_REQ, 1'b1);
        #2;
        flag_check("inval one cycle after ack", 1'b1, hpdc_inval_valid_o);
        drain_inval();
        #2;
        flag_check("final inval valid", 1'b0, hpdc_inval_valid_o);

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== list.f ====
common/l15_adapter_pkg.sv
request/l15_store_align.sv
request/l15_req_encode.sv
source/l15_thread_table.sv
source/l15_resp_decode.sv
source/l15_inval_fifo.sv
source/hpdc_l15_adapter.sv
test/tb_hpdc_l15_adapter.sv

// ==== run.sh ====
#!/bin/sh
# Builds the adapter testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module tb_hpdc_l15_adapter -f list.f -o tb_sim
out=$(./obj_dir/tb_sim || true)
echo "$out"
echo "$out" | grep -q "^TEST PASS$"
